//--- flist.f
+incdir+include
rtl/dcache_pkg.sv
rtl/way_ages.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tests/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f flist.f -o tb_dcache > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_dcache > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && exit 0 || exit 1

//--- include/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// one completed memory transfer
typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
} mem_event_t;

// what the memory store holds, and what a read must return
logic [WORD_W-1:0] flat_mem [logic [ADDR_W-1:0]];
logic [WORD_W-1:0] arch_mem [logic [ADDR_W-1:0]];

// predicted cache contents
logic [TAG_W-1:0]  m_tag   [NUM_SETS][2];
logic              m_valid [NUM_SETS][2];
logic              m_dirty [NUM_SETS][2];
logic [AGE_W-1:0]  m_age   [NUM_SETS][2];
logic [WORD_W-1:0] m_data  [NUM_SETS][2];

// unwritten memory, mixed from the whole address
function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], addr[63:32]};
endfunction

function automatic logic [WORD_W-1:0] flat_read(input logic [ADDR_W-1:0] addr);
    if (flat_mem.exists(addr)) begin
        return flat_mem[addr];
    end
    return fill_word(addr);
endfunction

function automatic logic [WORD_W-1:0] arch_read(input logic [ADDR_W-1:0] addr);
    if (arch_mem.exists(addr)) begin
        return arch_mem[addr];
    end
    return fill_word(addr);
endfunction

function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_word,
        input logic [WORD_W-1:0] new_word, input logic [STRB_W-1:0] strb);
    logic [WORD_W-1:0] res;
    int                b;
    res = old_word;
    for (b = 0; b < STRB_W; b++) begin
        if (strb[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
        end
    end
    return res;
endfunction

// -1 means a miss
function automatic int find_way(input logic [TAG_W-1:0] tag, input logic [INDEX_W-1:0] idx);
    int w;
    for (w = 0; w < 2; w++) begin
        if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
            return w;
        end
    end
    return -1;
endfunction

// free way first, way 0 before way 1, then the older way
function automatic int pick_victim(input logic [INDEX_W-1:0] idx);
    if (!m_valid[idx][0]) begin
        return 0;
    end
    if (!m_valid[idx][1]) begin
        return 1;
    end
    return (m_age[idx][1] > m_age[idx][0]) ? 1 : 0;
endfunction

function automatic void touch_line(input logic [INDEX_W-1:0] idx, input int way);
    if (m_age[idx][1-way] != AGE_MAX) begin
        m_age[idx][1-way] = m_age[idx][1-way] + 1'b1;
    end
    m_age[idx][way] = '0;
endfunction

function automatic void refill_line(input logic [INDEX_W-1:0] idx, input int way,
        input logic [TAG_W-1:0] tag, input logic [ADDR_W-1:0] line);
    m_tag[idx][way]   = tag;
    m_valid[idx][way] = 1'b1;
    m_dirty[idx][way] = 1'b0;
    m_data[idx][way]  = arch_read(line);
endfunction

function automatic void write_line(input logic [INDEX_W-1:0] idx, input int way,
        input logic [ADDR_W-1:0] line, input logic [WORD_W-1:0] wdata,
        input logic [STRB_W-1:0] strb);
    arch_mem[line]    = merge_bytes(arch_read(line), wdata, strb);
    m_data[idx][way]  = arch_mem[line];
    m_dirty[idx][way] = 1'b1;
endfunction

function automatic void clear_model();
    int s;
    for (s = 0; s < NUM_SETS; s++) begin
        m_valid[s][0] = 1'b0;
        m_valid[s][1] = 1'b0;
        m_dirty[s][0] = 1'b0;
        m_dirty[s][1] = 1'b0;
        m_age[s][0]   = '0;
        m_age[s][1]   = '0;
    end
endfunction

`endif

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          NUM_REQS       = 400;
    localparam int          TIMEOUT_CYCLES = NUM_REQS * 40;
    localparam logic [31:0] SEED           = 32'hb591_30f5;

    `include "tb_cache_model.svh"

    logic              clk;
    logic              reset_i;
    logic              req_valid;
    cpu_req_t          cpu_req;
    logic              req_ready;
    logic              resp_valid;
    logic [WORD_W-1:0] resp_rdata;
    mem_req_t          mem_req;
    mem_resp_t         mem_resp;

    logic [31:0]       lcg_state;
    int                errors;
    int                checks;
    int                cycle_count;
    mem_event_t        mem_events [$];

    // memory responder
    logic              mem_busy;
    mem_req_t          held_req;
    int                mem_delay;
    logic              ready_next;
    logic [WORD_W-1:0] rdata_next;

    dcache_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid),
        .cpu_req_i    (cpu_req),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .mem_req_o    (mem_req),
        .mem_resp_i   (mem_resp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    // four distinct tags spread over the field
    function automatic logic [TAG_W-1:0] tag_of(input int k);
        return 55'h2a_5a5a_0000_c3c3 ^ (TAG_W'(k) << 40) ^ TAG_W'(k);
    endfunction

    task automatic note_mismatch(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        errors++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // decides ready for the next cycle, records each finished transfer
    task automatic serve_memory();
        mem_event_t ev;
        if (reset_i) begin
            mem_busy   = 1'b0;
            ready_next = 1'b0;
        end else if (mem_req.valid === 1'b1) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                held_req  = mem_req;
                mem_delay = rand_below(6);
            end else begin
                checks++;
                if (mem_req !== held_req) begin
                    flag_error("mem_req_o changed while ready was low");
                end
            end
            if (mem_resp.ready) begin
                ev.write = mem_req.write;
                ev.addr  = mem_req.addr;
                ev.data  = mem_req.write ? mem_req.wdata : mem_resp.rdata;
                if (mem_req.write) begin
                    flat_mem[mem_req.addr] = mem_req.wdata;
                end
                mem_events.push_back(ev);
                mem_busy   = 1'b0;
                ready_next = 1'b0;
            end else if (mem_delay == 0) begin
                ready_next = 1'b1;
                rdata_next = mem_req.write ? '0 : flat_read(mem_req.addr);
            end else begin
                mem_delay--;
            end
        end else begin
            if (mem_busy) begin
                flag_error("mem_req_o dropped before ready");
            end
            mem_busy   = 1'b0;
            ready_next = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        serve_memory();
    end

    always @(posedge clk) begin
        #1;
        mem_resp.ready = ready_next;
        mem_resp.rdata = rdata_next;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a response never came", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_misses(input logic wb, input logic [ADDR_W-1:0] wb_addr,
            input logic [WORD_W-1:0] wb_data, input logic [ADDR_W-1:0] line);
        mem_event_t ev;
        if (wb) begin
            checks++;
            if (mem_events.size() == 0) begin
                flag_error("dirty victim was not written back");
            end else begin
                ev = mem_events.pop_front();
                if (!ev.write) begin
                    flag_error("expected a write-back, memory saw a read");
                end
                if (ev.addr !== wb_addr) begin
                    note_mismatch("mem_req_o.addr", ev.addr, wb_addr);
                end
                if (ev.data !== wb_data) begin
                    note_mismatch("mem_req_o.wdata", ev.data, wb_data);
                end
            end
        end
        checks++;
        if (mem_events.size() == 0) begin
            flag_error("miss finished without a refill");
        end else begin
            ev = mem_events.pop_front();
            if (ev.write) begin
                flag_error("write-back where only a refill was expected");
            end
            if (ev.addr !== line) begin
                note_mismatch("mem_req_o.addr", ev.addr, line);
            end
        end
    endtask

    task automatic run_request();
        cpu_req_t           req;
        logic [INDEX_W-1:0] idx;
        logic [ADDR_W-1:0]  line;
        int                 way;
        logic               hit;
        logic               wb;
        logic [ADDR_W-1:0]  wb_addr;
        logic [WORD_W-1:0]  wb_data;
        logic [WORD_W-1:0]  exp_rdata;
        int                 lat;
        logic               saw_mem;

        @(posedge clk);
        #1;
        repeat (rand_below(3)) begin
            @(posedge clk);
            #1;
        end
        req.write       = (rand_below(10) < 4);
        req.addr.tag    = tag_of(rand_below(4));
        req.addr.index  = INDEX_W'(rand_below(4) * 21);
        req.addr.offset = OFFSET_W'(rand_below(8));
        req.wdata       = {lcg_next(), lcg_next()};
        req.strb        = STRB_W'(rand_below(256));
        idx             = req.addr.index;
        line            = {req.addr.tag, idx, 3'b000};

        // prediction comes before the DUT sees the request
        way = find_way(req.addr.tag, idx);
        hit = (way >= 0);
        if (!hit) begin
            way = pick_victim(idx);
        end
        wb        = !hit && m_valid[idx][way] && m_dirty[idx][way];
        wb_addr   = {m_tag[idx][way], idx, 3'b000};
        wb_data   = m_data[idx][way];
        exp_rdata = arch_read(line);

        req_valid = 1'b1;
        cpu_req   = req;
        @(negedge clk);
        while (req_ready !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat       = 0;
        saw_mem   = 1'b0;
        do begin
            @(negedge clk);
            lat++;
            if (mem_req.valid === 1'b1) begin
                saw_mem = 1'b1;
            end
        end while (resp_valid !== 1'b1);

        if (hit) begin
            checks++;
            if (lat != 2) begin
                note_mismatch("hit latency", lat, 2);
            end
            checks++;
            if (saw_mem || mem_events.size() != 0) begin
                flag_error("memory request appeared during a hit");
            end
        end else begin
            check_misses(wb, wb_addr, wb_data, line);
        end
        checks++;
        if (mem_events.size() != 0) begin
            flag_error("extra memory transfers for one request");
            mem_events.delete();
        end
        if (!req.write) begin
            checks++;
            if (resp_rdata !== exp_rdata) begin
                note_mismatch("resp_rdata_o", resp_rdata, exp_rdata);
            end
        end

        if (!hit) begin
            refill_line(idx, way, req.addr.tag, line);
        end
        touch_line(idx, way);
        if (req.write) begin
            write_line(idx, way, line, req.wdata, req.strb);
        end
    endtask

    // memory plus dirty cached lines must hold every architectural value
    task automatic check_final_memory();
        logic [INDEX_W-1:0] idx;
        logic [ADDR_W-1:0]  line;
        logic [WORD_W-1:0]  held;
        int                 t;
        int                 s;
        int                 way;
        for (t = 0; t < 4; t++) begin
            for (s = 0; s < 4; s++) begin
                idx  = INDEX_W'(s * 21);
                line = {tag_of(t), idx, 3'b000};
                way  = find_way(tag_of(t), idx);
                held = flat_read(line);
                if (way >= 0 && m_dirty[idx][way]) begin
                    held = m_data[idx][way];
                end
                checks++;
                if (held !== arch_read(line)) begin
                    note_mismatch("memory image", held, arch_read(line));
                end
            end
        end
    endtask

    initial begin
        int n;
        clk         = 1'b0;
        reset_i     = 1'b1;
        req_valid   = 1'b0;
        cpu_req     = '0;
        mem_resp    = '0;
        ready_next  = 1'b0;
        rdata_next  = '0;
        mem_busy    = 1'b0;
        mem_delay   = 0;
        lcg_state   = SEED;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        clear_model();

        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(negedge clk);
        checks++;
        if (req_ready !== 1'b1) begin
            note_mismatch("req_ready_o", req_ready, 1);
        end
        checks++;
        if (resp_valid !== 1'b0) begin
            note_mismatch("resp_valid_o", resp_valid, 0);
        end
        checks++;
        if (mem_req.valid !== 1'b0) begin
            note_mismatch("mem_req_o.valid", mem_req.valid, 0);
        end

        for (n = 0; n < NUM_REQS; n++) begin
            run_request();
        end
        check_final_memory();

        $display("Finished %0d requests, %0d checks, %0d errors", NUM_REQS, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic         req_valid_i,
    input  wire cpu_req_t     cpu_req_i,
    output logic              req_ready_o,
    output logic              resp_valid_o,
    output logic [WORD_W-1:0] resp_rdata_o,
    output mem_req_t          mem_req_o,
    input  wire mem_resp_t    mem_resp_i
);

    lookup_t             lookup;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    lookup_tag;
    logic                touch;
    logic                touch_way;
    logic                tag_wr;
    logic                tag_wr_way;
    logic                tag_wr_dirty;
    logic                data_wr_way;
    logic [STRB_W-1:0]   data_wr_strb;
    logic [WORD_W-1:0]   data_wr_word;
    logic                rd_way;
    logic [WORD_W-1:0]   rd_word;
    logic                victim_way;
    logic [1:0]          set_valid;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .cpu_req_i      (cpu_req_i),
        .req_ready_o    (req_ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_resp_i     (mem_resp_i),
        .lookup_i       (lookup),
        .index_o        (index),
        .lookup_tag_o   (lookup_tag),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .tag_wr_o       (tag_wr),
        .tag_wr_way_o   (tag_wr_way),
        .tag_wr_dirty_o (tag_wr_dirty),
        .data_wr_way_o  (data_wr_way),
        .data_wr_strb_o (data_wr_strb),
        .data_wr_word_o (data_wr_word),
        .rd_way_o       (rd_way),
        .rd_word_i      (rd_word)
    );

    way_ages u_ages (
        .clk          (clk),
        .reset_i      (reset_i),
        .index_i      (index),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .valid_i      (set_valid),
        .victim_way_o (victim_way)
    );

    tag_array u_tags (
        .clk          (clk),
        .reset_i      (reset_i),
        .index_i      (index),
        .lookup_tag_i (lookup_tag),
        .victim_way_i (victim_way),
        .wr_i         (tag_wr),
        .wr_way_i     (tag_wr_way),
        .wr_dirty_i   (tag_wr_dirty),
        .valid_o      (set_valid),
        .lookup_o     (lookup)
    );

    data_array u_data (
        .clk       (clk),
        .index_i   (index),
        .wr_way_i  (data_wr_way),
        .wr_strb_i (data_wr_strb),
        .wr_word_i (data_wr_word),
        .rd_way_i  (rd_way),
        .rd_word_o (rd_word)
    );

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               req_valid_i,
    input  wire cpu_req_t           cpu_req_i,
    output logic                    req_ready_o,
    output logic                    resp_valid_o,
    output logic [WORD_W-1:0]       resp_rdata_o,
    output mem_req_t                mem_req_o,
    input  wire mem_resp_t          mem_resp_i,
    input  wire lookup_t            lookup_i,
    output logic [INDEX_W-1:0]      index_o,
    output logic [TAG_W-1:0]        lookup_tag_o,
    output logic                    touch_o,
    output logic                    touch_way_o,
    output logic                    tag_wr_o,
    output logic                    tag_wr_way_o,
    output logic                    tag_wr_dirty_o,
    output logic                    data_wr_way_o,
    output logic [STRB_W-1:0]       data_wr_strb_o,
    output logic [WORD_W-1:0]       data_wr_word_o,
    output logic                    rd_way_o,
    input  wire logic [WORD_W-1:0]  rd_word_i
);

    ctrl_state_t      state_q;
    ctrl_state_t      state_d;
    cpu_req_t         req_q;
    logic             sel_way_q;
    logic [TAG_W-1:0] victim_tag_q;
    logic             refill_done;
    logic             write_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_i.hit) begin
                    state_d = RESPOND;
                end else if (lookup_i.victim_valid && lookup_i.victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            WRITEBACK: begin
                if (mem_resp_i.ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // look up again so the new line hits
                if (mem_resp_i.ready) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= cpu_req_i;
        end
        // way to hit on, or to evict and refill
        if (state_q == LOOKUP) begin
            sel_way_q    <= lookup_i.hit_way;
            victim_tag_q <= lookup_i.victim_tag;
        end
    end

    assign req_ready_o  = (state_q == IDLE);
    assign resp_valid_o = (state_q == RESPOND);
    assign resp_rdata_o = rd_word_i;

    // arrays read with one cycle latency, so present the new index while idle
    assign index_o      = (state_q == IDLE) ? cpu_req_i.addr.index : req_q.addr.index;
    assign lookup_tag_o = req_q.addr.tag;
    assign rd_way_o     = sel_way_q;

    assign touch_o     = (state_q == RESPOND);
    assign touch_way_o = sel_way_q;

    assign refill_done = (state_q == REFILL) && mem_resp_i.ready;
    assign write_hit   = (state_q == RESPOND) && req_q.write;

    assign tag_wr_o       = refill_done || write_hit;
    assign tag_wr_way_o   = sel_way_q;
    assign tag_wr_dirty_o = write_hit;

    assign data_wr_way_o  = sel_way_q;
    assign data_wr_strb_o = refill_done ? {STRB_W{1'b1}} :
                            write_hit   ? req_q.strb     : '0;
    assign data_wr_word_o = refill_done ? mem_resp_i.rdata : req_q.wdata;

    // write-back goes to the victim's own line address
    always_comb begin
        mem_req_o            = '0;
        mem_req_o.valid      = (state_q == WRITEBACK) || (state_q == REFILL);
        mem_req_o.write      = (state_q == WRITEBACK);
        mem_req_o.addr.index = req_q.addr.index;
        mem_req_o.addr.tag   = (state_q == WRITEBACK) ? victim_tag_q : req_q.addr.tag;
        mem_req_o.wdata      = (state_q == WRITEBACK) ? rd_word_i : '0;
    end

    // a response comes from a line that still hits in the way being read
    a_no_resp_during_mem: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_o |-> (!mem_req_o.valid && lookup_i.hit && lookup_i.hit_way == rd_way_o));

    a_mem_req_held: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o.valid && !mem_resp_i.ready) |=> (mem_req_o.valid && $stable(mem_req_o)));

endmodule

`default_nettype wire

//--- rtl/data_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_array
    import dcache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic [INDEX_W-1:0] index_i,
    input  wire logic               wr_way_i,
    input  wire logic [STRB_W-1:0]  wr_strb_i,
    input  wire logic [WORD_W-1:0]  wr_word_i,
    input  wire logic               rd_way_i,
    output logic [WORD_W-1:0]       rd_word_o
);

    logic [WORD_W-1:0] mem  [2][NUM_SETS];
    logic [WORD_W-1:0] rd_q [2];

    // byte lanes, an empty strobe means no write
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_way_i == 1'(w) && wr_strb_i[b]) begin
                    mem[w][index_i][8*b +: 8] <= wr_word_i[8*b +: 8];
                end
            end
        end
    end

    // both ways read every cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_q[w] <= mem[w][index_i];
        end
    end

    // hit way on a response, victim way on a write-back
    assign rd_word_o = rd_q[rd_way_i];

endmodule

`default_nettype wire

//--- rtl/tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array
    import dcache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [INDEX_W-1:0] index_i,
    input  wire logic [TAG_W-1:0]   lookup_tag_i,
    input  wire logic               victim_way_i,
    input  wire logic               wr_i,
    input  wire logic               wr_way_i,
    input  wire logic               wr_dirty_i,
    output logic [1:0]              valid_o,
    output lookup_t                 lookup_o
);

    logic [1:0][NUM_SETS-1:0] valid_mem;
    logic [TAG_W-1:0]         tag_mem   [2][NUM_SETS];
    logic                     dirty_mem [2][NUM_SETS];

    logic [1:0]               valid_q;
    logic [1:0]               dirty_q;
    logic [TAG_W-1:0]         tag_q     [2];
    logic [1:0]               hit_vec;

    // read is write-first so a refilled line hits on the next lookup
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_mem <= '0;
            valid_q   <= '0;
        end else begin
            if (wr_i) begin
                valid_mem[wr_way_i][index_i] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= valid_mem[w][index_i] || (wr_i && wr_way_i == 1'(w));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_mem[wr_way_i][index_i]   <= lookup_tag_i;
            dirty_mem[wr_way_i][index_i] <= wr_dirty_i;
        end
        for (int w = 0; w < 2; w++) begin
            if (wr_i && wr_way_i == 1'(w)) begin
                tag_q[w]   <= lookup_tag_i;
                dirty_q[w] <= wr_dirty_i;
            end else begin
                tag_q[w]   <= tag_mem[w][index_i];
                dirty_q[w] <= dirty_mem[w][index_i];
            end
        end
    end

    assign hit_vec[0] = valid_q[0] && (tag_q[0] == lookup_tag_i);
    assign hit_vec[1] = valid_q[1] && (tag_q[1] == lookup_tag_i);

    assign valid_o               = valid_q;
    assign lookup_o.hit          = |hit_vec;
    assign lookup_o.hit_way      = (|hit_vec) ? hit_vec[1] : victim_way_i;
    assign lookup_o.victim_valid = valid_q[victim_way_i];
    assign lookup_o.victim_dirty = dirty_q[victim_way_i];
    assign lookup_o.victim_tag   = tag_q[victim_way_i];

    // refills only follow a miss, so a tag never lives in both ways
    a_single_hit: assert property (@(posedge clk) disable iff (reset_i)
        !(hit_vec[0] && hit_vec[1]));

endmodule

`default_nettype wire

//--- rtl/way_ages.sv
`timescale 1ns/1ps
`default_nettype none

module way_ages
    import dcache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [INDEX_W-1:0] index_i,
    input  wire logic               touch_i,
    input  wire logic               touch_way_i,
    input  wire logic [1:0]         valid_i,
    output logic                    victim_way_o
);

    logic [NUM_SETS-1:0][1:0][AGE_W-1:0] age_q;
    logic [1:0][AGE_W-1:0]               set_age;

    function automatic logic [AGE_W-1:0] sat_inc(input logic [AGE_W-1:0] age);
        logic [AGE_W-1:0] nxt;
        nxt = (age == AGE_W'(AGE_MAX)) ? age : age + 1'b1;
        return nxt;
    endfunction

    assign set_age = age_q[index_i];

    // touched way becomes youngest, the other one ages
    always_ff @(posedge clk) begin
        if (reset_i) begin
            age_q <= '0;
        end else if (touch_i) begin
            age_q[index_i][touch_way_i]  <= '0;
            age_q[index_i][~touch_way_i] <= sat_inc(set_age[~touch_way_i]);
        end
    end

    // free way first, else the older one, way 0 on a tie
    always_comb begin
        if (!valid_i[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = (set_age[1] > set_age[0]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // address split: tag | index | byte offset
    localparam int ADDR_W   = 64;
    localparam int WORD_W   = 64;
    localparam int STRB_W   = WORD_W / 8;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    // per-way age counters, saturating
    localparam int AGE_W   = 3;
    localparam int AGE_MAX = (1 << AGE_W) - 1;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } dcache_addr_t;

    typedef struct packed {
        logic              write;
        dcache_addr_t      addr;
        logic [WORD_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        dcache_addr_t      addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              ready;
        logic [WORD_W-1:0] rdata;
    } mem_resp_t;

    // hit_way carries the victim way when there is no hit
    typedef struct packed {
        logic             hit;
        logic             hit_way;
        logic             victim_valid;
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire
